// File: verif/fetch_patterns.txt
# columns: base_addr key wait_en, all hex
# one weight fetch per line
00000000 00000000 0
00001000 a5a5a5a5 0
00020040 1234abcd 1
7fff0000 deadbeef 1
00000200 0f0f3c3c 1
00001000 5a5a0ff0 0

// File: all.f
+incdir+verilog
verilog/stmm_pkg.sv
verilog/weight_bram.sv
verilog/beat_collector.sv
verilog/sdram_burst_reader.sv
verilog/stmm_fetch_ctrl.sv
verilog/stmm_fetch_top.sv
verif/tb_clkgen.sv
verif/sdram_slave_model.sv
verif/stmm_fetch_props.sv
verif/tb_stmm_fetch.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_stmm_fetch"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_stmm_fetch -Mdir obj_dir -o sim
	./obj_dir/sim 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_stmm_fetch.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module tb_stmm_fetch;

    localparam int WAIT_LIMIT = 4000;
    localparam logic [31:0] LINE_BYTES = `STMM_BLK_NUM * `STMM_BEAT_BYTES;

    logic                     clk;
    logic                     rst_n;
    logic                     i_start;
    logic [`STMM_ADDR_W-1:0]  i_fetch_addr;
    logic                     o_done;
    stmm_pkg::quant_t         o_quant;
    logic                     o_quant_valid;
    stmm_pkg::avm_cmd_t       o_avm_cmd;
    stmm_pkg::avm_rsp_t       i_avm_rsp;
    logic [`STMM_LINE_AW-1:0] i_bram_rd_addr;
    logic [`STMM_LINE_W-1:0]  o_bram_rd_data;
    logic [31:0]              key;
    logic                     wait_en;

    // accepted commands and quant-valid pulses seen so far
    stmm_pkg::avm_cmd_t acc_q[$];
    int                 qv_cnt = 0;

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

    sdram_slave_model u_sdram (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wait_en (wait_en),
        .i_key     (key),
        .i_cmd     (o_avm_cmd),
        .o_rsp     (i_avm_rsp)
    );

    stmm_fetch_top u_stmm_fetch_top (.*);

    always @(posedge clk) begin
        if (rst_n && o_avm_cmd.read && !i_avm_rsp.waitrequest) begin
            acc_q.push_back(o_avm_cmd);
        end
        if (rst_n && o_quant_valid) begin
            qv_cnt++;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_cmd(input string name, input stmm_pkg::avm_cmd_t got,
                             input stmm_pkg::avm_cmd_t exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_line(input string name, input logic [`STMM_LINE_W-1:0] got,
                              input logic [`STMM_LINE_W-1:0] exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_quant(input string name, input stmm_pkg::quant_t got,
                               input stmm_pkg::quant_t exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // one fetch with its expected results
    //////////////////////////////////////////////////
    task automatic run_fetch(input logic [31:0] base, input logic [31:0] key_val,
                             input logic wen);
        logic [31:0]             qword;
        logic [31:0]             addr;
        logic [`STMM_LINE_W-1:0] exp_line;
        stmm_pkg::quant_t        exp_quant;
        stmm_pkg::avm_cmd_t      exp_cmd;
        int                      acc_base;
        int                      qv_base;
        int                      n;
        acc_base = acc_q.size();
        qv_base  = qv_cnt;
        key          <= key_val;
        wait_en      <= wen;
        i_start      <= 1'b1;
        i_fetch_addr <= base;
        @(posedge clk);
        i_start      <= 1'b0;
        i_fetch_addr <= ~base;
        repeat (5) @(posedge clk);
        check_bit("o_done", o_done, 1'b0);
        // a second start mid-fetch must not disturb it
        i_start      <= 1'b1;
        i_fetch_addr <= base ^ 32'h0ff0_0000;
        @(posedge clk);
        i_start <= 1'b0;
        n = 0;
        while (!o_quant_valid && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!o_quant_valid) fail_now("timeout waiting for o_quant_valid");
        check_bit("o_done", o_done, 1'b1);
        // quant word sits right after the last line
        qword = (base + LINE_BYTES * `STMM_BRAM_L) ^ key_val;
        exp_quant.scale_fp16 = qword[15:0];
        exp_quant.z_x        = qword[7:0];
        exp_quant.z_w        = qword[7:0];
        exp_quant.zero       = qword[7:0];
        check_quant("o_quant", o_quant, exp_quant);
        if (acc_q.size() - acc_base != `STMM_BRAM_L + 1) begin
            fail_now($sformatf("fetch issued %0d read commands instead of %0d",
                               acc_q.size() - acc_base, `STMM_BRAM_L + 1));
        end
        for (int j = 0; j <= `STMM_BRAM_L; j++) begin
            exp_cmd.read       = 1'b1;
            exp_cmd.address    = base + LINE_BYTES * 32'(j);
            exp_cmd.burstcount = (j == `STMM_BRAM_L) ? 11'd1 : 11'(`STMM_BLK_NUM);
            check_cmd("o_avm_cmd", acc_q[acc_base + j], exp_cmd);
        end
        for (int j = 0; j < `STMM_BRAM_L; j++) begin
            i_bram_rd_addr <= 3'(j);
            @(posedge clk);
            @(posedge clk);
            for (int k = 0; k < `STMM_BLK_NUM; k++) begin
                addr = base + LINE_BYTES * 32'(j) + `STMM_BEAT_BYTES * k;
                exp_line[k * `STMM_SDRAM_W +: `STMM_SDRAM_W] = {4{addr ^ key_val}};
            end
            check_line($sformatf("o_bram_rd_data[line %0d]", j), o_bram_rd_data, exp_line);
        end
        if (qv_cnt - qv_base != 1) begin
            fail_now($sformatf("o_quant_valid pulsed %0d times in one fetch", qv_cnt - qv_base));
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          fetches;
        string       text;
        logic [31:0] p_base;
        logic [31:0] p_key;
        logic [31:0] p_wait;
        i_start        = 1'b0;
        i_fetch_addr   = '0;
        i_bram_rd_addr = '0;
        key            = '0;
        wait_en        = 1'b0;
        fetches        = 0;
        fd = $fopen("verif/fetch_patterns.txt", "r");
        if (fd == 0) fail_now("could not open verif/fetch_patterns.txt");
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) fail_now("timeout waiting for reset release");
        repeat (4) @(posedge clk);
        check_bit("o_done", o_done, 1'b1);
        check_bit("o_quant_valid", o_quant_valid, 1'b0);
        check_cmd("o_avm_cmd", o_avm_cmd, '0);
        if (acc_q.size() != 0) fail_now("read command accepted before any start");
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 0 && text.len() > 1 && text[0] != "#") begin
                if ($sscanf(text, "%h %h %h", p_base, p_key, p_wait) != 3) begin
                    fail_now("malformed line in the pattern file");
                end
                run_fetch(p_base, p_key, p_wait[0]);
                fetches++;
            end
        end
        $fclose(fd);
        if (fetches == 0) begin
            fail_now("pattern file holds no fetch");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: verif/stmm_fetch_props.sv
`timescale 1ns/100ps

module stmm_fetch_props (
    input  logic                clk,
    input  logic                rst_n,
    input  stmm_pkg::avm_cmd_t  i_avm_cmd,
    input  stmm_pkg::avm_rsp_t  i_avm_rsp,
    input  logic                i_done,
    input  logic                i_quant_valid,
    input  stmm_pkg::line_wr_t  i_line_wr
);

    // command held while the slave stalls
    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_avm_cmd.read && i_avm_rsp.waitrequest) |=> $stable(i_avm_cmd))
        else $error("read command changed while waitrequest was high");

    a_quant_valid_on_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        i_quant_valid |-> $rose(i_done))
        else $error("o_quant_valid seen without o_done rising");

    a_no_write_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_line_wr.we |-> !i_done)
        else $error("BRAM write while o_done is high");

endmodule

bind stmm_fetch_top stmm_fetch_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_avm_cmd     (o_avm_cmd),
    .i_avm_rsp     (i_avm_rsp),
    .i_done        (o_done),
    .i_quant_valid (o_quant_valid),
    .i_line_wr     (line_wr)
);

// File: verif/sdram_slave_model.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module sdram_slave_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_wait_en,
    input  logic [31:0]         i_key,
    input  stmm_pkg::avm_cmd_t  i_cmd,
    output stmm_pkg::avm_rsp_t  o_rsp
);

    logic [15:0]              lfsr;
    logic [15:0]              lfsr_nxt;
    logic [`STMM_ADDR_W-1:0]  beat_addr;
    logic [`STMM_BURST_W-1:0] beats_left;
    logic [1:0]               delay;

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    assign lfsr_nxt = lfsr_step(lfsr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr       <= 16'd41587;
            o_rsp      <= '0;
            beat_addr  <= '0;
            beats_left <= '0;
            delay      <= '0;
        end else begin
            // one LFSR step per waitrequest bit
            if (i_wait_en) begin
                lfsr              <= lfsr_nxt;
                o_rsp.waitrequest <= lfsr_nxt[0];
            end else begin
                o_rsp.waitrequest <= 1'b0;
            end
            o_rsp.readdatavalid <= 1'b0;
            if (i_cmd.read && !o_rsp.waitrequest) begin
                beat_addr  <= i_cmd.address;
                beats_left <= i_cmd.burstcount;
                delay      <= 2'd1;
            end else if (delay != 0) begin
                delay <= delay - 1'b1;
            end else if (beats_left != 0) begin
                o_rsp.readdatavalid <= 1'b1;
                o_rsp.readdata      <= {4{beat_addr ^ i_key}};
                beat_addr           <= beat_addr + `STMM_BEAT_BYTES;
                beats_left          <= beats_left - 1'b1;
            end
        end
    end

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // reset held low for 8 cycles
    initial begin
        o_rst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// File: verilog/stmm_fetch_top.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module stmm_fetch_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_start,
    input  logic [`STMM_ADDR_W-1:0]     i_fetch_addr,
    output logic                        o_done,
    output stmm_pkg::quant_t            o_quant,
    output logic                        o_quant_valid,
    output stmm_pkg::avm_cmd_t          o_avm_cmd,
    input  stmm_pkg::avm_rsp_t          i_avm_rsp,
    input  logic [`STMM_LINE_AW-1:0]    i_bram_rd_addr,
    output logic [`STMM_LINE_W-1:0]     o_bram_rd_data
);

    stmm_pkg::rd_req_t  rd_req;
    stmm_pkg::rd_rsp_t  rd_rsp;
    stmm_pkg::line_wr_t line_wr;

    logic beat_store;
    logic beat_clear;
    logic quant_capture;

    stmm_fetch_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_start         (i_start),
        .i_fetch_addr    (i_fetch_addr),
        .i_rd_rsp        (rd_rsp),
        .o_rd_req        (rd_req),
        .o_beat_store    (beat_store),
        .o_beat_clear    (beat_clear),
        .o_quant_capture (quant_capture),
        .o_line_we       (line_wr.we),
        .o_line_addr     (line_wr.addr),
        .o_quant_valid   (o_quant_valid),
        .o_done          (o_done)
    );

    sdram_burst_reader u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rd_req  (rd_req),
        .o_avm_cmd (o_avm_cmd),
        .i_avm_rsp (i_avm_rsp),
        .o_rd_rsp  (rd_rsp)
    );

    beat_collector u_collector (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_rd_rsp        (rd_rsp),
        .i_beat_store    (beat_store),
        .i_beat_clear    (beat_clear),
        .i_quant_capture (quant_capture),
        .o_line_data     (line_wr.data),
        .o_quant         (o_quant)
    );

    weight_bram u_bram (
        .clk       (clk),
        .i_line_wr (line_wr),
        .i_rd_addr (i_bram_rd_addr),
        .o_rd_data (o_bram_rd_data)
    );

endmodule

// File: verilog/stmm_fetch_ctrl.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module stmm_fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_start,
    input  logic [`STMM_ADDR_W-1:0]     i_fetch_addr,
    input  stmm_pkg::rd_rsp_t           i_rd_rsp,
    output stmm_pkg::rd_req_t           o_rd_req,
    output logic                        o_beat_store,
    output logic                        o_beat_clear,
    output logic                        o_quant_capture,
    output logic                        o_line_we,
    output logic [`STMM_LINE_AW-1:0]    o_line_addr,
    output logic                        o_quant_valid,
    output logic                        o_done
);

    localparam int BURST_W = `STMM_BURST_W;
    localparam logic [BURST_W-1:0] CNT_LINE  = BURST_W'(`STMM_BLK_NUM);
    localparam logic [BURST_W-1:0] CNT_QUANT = BURST_W'(1);
    // 64 bytes per line
    localparam logic [`STMM_ADDR_W-1:0] LINE_STRIDE = `STMM_BLK_NUM * `STMM_BEAT_BYTES;

    typedef enum logic [1:0] {
        IDLE,
        RECV_MAT,
        RECV_QUANT
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [`STMM_ADDR_W-1:0]  byte_addr;
    logic [`STMM_LINE_AW-1:0] line_addr;
    logic                     last_line;
    logic                     quant_valid_r;

    assign last_line = (int'(line_addr) == `STMM_BRAM_L - 1);

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next state and strobes
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt       = state;
        o_rd_req.start  = 1'b0;
        // next line follows the one in flight
        o_rd_req.addr   = byte_addr + LINE_STRIDE;
        o_rd_req.cnt    = CNT_LINE;
        o_beat_store    = 1'b0;
        o_beat_clear    = 1'b0;
        o_quant_capture = 1'b0;
        o_line_we       = 1'b0;

        case (state)
            IDLE: begin
                o_rd_req.addr = i_fetch_addr;
                if (i_start) begin
                    o_rd_req.start = 1'b1;
                    o_beat_clear   = 1'b1;
                    state_nxt      = RECV_MAT;
                end
            end
            RECV_MAT: begin
                o_beat_store = i_rd_rsp.valid;
                if (i_rd_rsp.done) begin
                    // line buffer is complete here
                    o_line_we      = 1'b1;
                    o_beat_clear   = 1'b1;
                    o_rd_req.start = 1'b1;
                    if (last_line) begin
                        o_rd_req.cnt = CNT_QUANT;
                        state_nxt    = RECV_QUANT;
                    end
                end
            end
            RECV_QUANT: begin
                if (i_rd_rsp.valid) begin
                    o_quant_capture = 1'b1;
                    state_nxt       = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // address counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_addr <= '0;
            line_addr <= '0;
        end else if (state == IDLE && i_start) begin
            byte_addr <= i_fetch_addr;
            line_addr <= '0;
        end else if (state == RECV_MAT && i_rd_rsp.done) begin
            byte_addr <= byte_addr + LINE_STRIDE;
            line_addr <= line_addr + 1'b1;
        end
    end

    // quant fields land in the collector on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quant_valid_r <= 1'b0;
        end else begin
            quant_valid_r <= o_quant_capture;
        end
    end

    assign o_line_addr   = line_addr;
    assign o_quant_valid = quant_valid_r;
    assign o_done        = (state == IDLE);

endmodule

// File: verilog/sdram_burst_reader.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module sdram_burst_reader (
    input  logic                clk,
    input  logic                rst_n,
    input  stmm_pkg::rd_req_t   i_rd_req,
    output stmm_pkg::avm_cmd_t  o_avm_cmd,
    input  stmm_pkg::avm_rsp_t  i_avm_rsp,
    output stmm_pkg::rd_rsp_t   o_rd_rsp
);

    stmm_pkg::avm_cmd_t cmd_r;

    logic [`STMM_BURST_W-1:0] beats_left;
    logic                     last_beat;
    logic                     valid_r;
    logic                     last_r;
    logic                     done_r;
    logic [`STMM_SDRAM_W-1:0] data_r;

    //////////////////////////////////////////////////
    // read command, held until accepted
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_r <= '0;
        end else if (i_rd_req.start) begin
            cmd_r.read       <= 1'b1;
            cmd_r.address    <= i_rd_req.addr;
            cmd_r.burstcount <= i_rd_req.cnt;
        end else if (cmd_r.read && !i_avm_rsp.waitrequest) begin
            cmd_r.read <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // beat counting
    //////////////////////////////////////////////////
    assign last_beat = i_avm_rsp.readdatavalid && (beats_left == 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beats_left <= '0;
        end else if (i_rd_req.start) begin
            beats_left <= i_rd_req.cnt;
        end else if (i_avm_rsp.readdatavalid && beats_left != 0) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // valid one cycle after readdatavalid, done one more after the last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            last_r  <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            valid_r <= i_avm_rsp.readdatavalid;
            last_r  <= last_beat;
            done_r  <= last_r;
        end
    end

    always_ff @(posedge clk) begin
        if (i_avm_rsp.readdatavalid) begin
            data_r <= i_avm_rsp.readdata;
        end
    end

    assign o_avm_cmd      = cmd_r;
    assign o_rd_rsp.valid = valid_r;
    assign o_rd_rsp.done  = done_r;
    assign o_rd_rsp.data  = data_r;

endmodule

// File: verilog/beat_collector.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module beat_collector (
    input  logic                        clk,
    input  logic                        rst_n,
    input  stmm_pkg::rd_rsp_t           i_rd_rsp,
    input  logic                        i_beat_store,
    input  logic                        i_beat_clear,
    input  logic                        i_quant_capture,
    output logic [`STMM_LINE_W-1:0]     o_line_data,
    output stmm_pkg::quant_t            o_quant
);

    localparam int IDX_W = $clog2(`STMM_BLK_NUM);

    logic [IDX_W-1:0] beat_idx;
    // slot k sits at line bits k*128 upward
    logic [`STMM_BLK_NUM-1:0][`STMM_SDRAM_W-1:0] line_buf;
    stmm_pkg::quant_t quant_r;

    //////////////////////////////////////////////////
    // beat index
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (i_beat_clear) begin
            beat_idx <= '0;
        end else if (i_beat_store) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_beat_store) begin
            line_buf[beat_idx] <= i_rd_rsp.data;
        end
    end

    //////////////////////////////////////////////////
    // quantization word
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_quant_capture) begin
            quant_r.scale_fp16 <= i_rd_rsp.data[96 +: 16];
            quant_r.z_x        <= $signed(i_rd_rsp.data[0 +: 8]);
            quant_r.z_w        <= $signed(i_rd_rsp.data[32 +: 8]);
            quant_r.zero       <= $signed(i_rd_rsp.data[64 +: 8]);
        end
    end

    assign o_line_data = line_buf;
    assign o_quant     = quant_r;

endmodule

// File: verilog/weight_bram.sv
`timescale 1ns/100ps
`include "stmm_config.svh"

module weight_bram (
    input  logic                        clk,
    input  stmm_pkg::line_wr_t          i_line_wr,
    input  logic [`STMM_LINE_AW-1:0]    i_rd_addr,
    output logic [`STMM_LINE_W-1:0]     o_rd_data
);

    logic [`STMM_LINE_W-1:0] mem [0:`STMM_BRAM_L-1];
    logic [`STMM_LINE_W-1:0] rd_data_r;

    //////////////////////////////////////////////////
    // write port, loader side
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_line_wr.we) begin
            mem[i_line_wr.addr] <= i_line_wr.data;
        end
    end

    //////////////////////////////////////////////////
    // read port, one cycle latency
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        rd_data_r <= mem[i_rd_addr];
    end

    assign o_rd_data = rd_data_r;

endmodule

// File: verilog/stmm_pkg.sv
`include "stmm_config.svh"

package stmm_pkg;

    //////////////////////////////////////////////////
    // controller <-> burst reader
    //////////////////////////////////////////////////

    // one-cycle start, addr and cnt sampled with it
    typedef struct packed {
        logic                     start;
        logic [`STMM_ADDR_W-1:0]  addr;
        logic [`STMM_BURST_W-1:0] cnt;
    } rd_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     done;
        logic [`STMM_SDRAM_W-1:0] data;
    } rd_rsp_t;

    //////////////////////////////////////////////////
    // Avalon-MM read master
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                     read;
        logic [`STMM_ADDR_W-1:0]  address;
        logic [`STMM_BURST_W-1:0] burstcount;
    } avm_cmd_t;

    typedef struct packed {
        logic [`STMM_SDRAM_W-1:0] readdata;
        logic                     readdatavalid;
        logic                     waitrequest;
    } avm_rsp_t;

    //////////////////////////////////////////////////
    // BRAM write port and quant parameters
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                     we;
        logic [`STMM_LINE_AW-1:0] addr;
        logic [`STMM_LINE_W-1:0]  data;
    } line_wr_t;

    typedef struct packed {
        logic [15:0]        scale_fp16;
        logic signed [7:0]  z_x;
        logic signed [7:0]  z_w;
        logic signed [7:0]  zero;
    } quant_t;

endpackage

// File: verilog/stmm_config.svh
`ifndef STMM_CONFIG_SVH
`define STMM_CONFIG_SVH

//////////////////////////////////////////////////
// SDRAM side
//////////////////////////////////////////////////

// one Avalon beat
`define STMM_SDRAM_W     128
`define STMM_ADDR_W      32
`define STMM_BURST_W     11
// byte stride between consecutive beats
`define STMM_BEAT_BYTES  16

//////////////////////////////////////////////////
// weight BRAM side
//////////////////////////////////////////////////

// beats packed into one BRAM line
`define STMM_BLK_NUM     4
`define STMM_LINE_W      (`STMM_SDRAM_W * `STMM_BLK_NUM)
// lines per weight matrix
`define STMM_BRAM_L      8
`define STMM_LINE_AW     3

`endif
